//--- vlog.f
+incdir+design
design/tsp_pkg.sv
design/opt_if.sv
design/opt_decode.sv
design/route_store.sv
design/route_sequencer.sv
design/route_rewrite.sv
design/route_result.sv
design/tsp_route_top.sv
verification/tsp_route_tb.sv

//--- Bender.yml
package:
  name: tsp_route

sources:
  - include_dirs:
      - design
    files:
      - design/tsp_pkg.sv
      - design/opt_if.sv
      - design/opt_decode.sv
      - design/route_store.sv
      - design/route_sequencer.sv
      - design/route_rewrite.sv
      - design/route_result.sv
      - design/tsp_route_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/tsp_route_tb.sv

//--- verification/tsp_route_tb.sv
`include "tsp_settings.svh"

module tsp_route_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_POS  = `TSP_LANES * `TSP_WORDS;
    localparam int CW     = `TSP_CITY_W;
    localparam int WW     = `TSP_LANES * `TSP_CITY_W;
    localparam int N_CMDS = 70;
    localparam int LIMIT  = N_CMDS * 20 + `TSP_WORDS + 10 + 100; // load, reset and a margin.

    typedef logic [N_POS*CW-1:0] tour_t; // position p sits at bits p*CW.

    logic                 clk;
    logic                 reset;
    logic                 cmd_valid_i;
    tsp_pkg::opt_kind_e   cmd_kind_i;
    tsp_pkg::pos_t        cmd_k_i;
    tsp_pkg::pos_t        cmd_l_i;
    logic                 cmd_reject_o;
    logic                 busy_o;
    logic                 load_valid_i;
    tsp_pkg::word_addr_t  load_addr_i;
    tsp_pkg::route_word_t load_data_i;
    logic                 out_valid_o;
    tsp_pkg::word_addr_t  out_addr_o;
    tsp_pkg::route_word_t out_data_o;
    logic                 done_o;

    tour_t  tour;
    tour_t  exp_tour;
    string  test_name;
    integer seed;
    int     cycle = 0;
    int     cmd_cycle = 0;
    int     words_seen = 0;
    int     mismatches = 0;
    int     failures = 0;
    logic   pass_open = 1'b0;

    tsp_route_top uut (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_kind_i   (cmd_kind_i),
        .cmd_k_i      (cmd_k_i),
        .cmd_l_i      (cmd_l_i),
        .cmd_reject_o (cmd_reject_o),
        .busy_o       (busy_o),
        .load_valid_i (load_valid_i),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i),
        .out_valid_o  (out_valid_o),
        .out_addr_o   (out_addr_o),
        .out_data_o   (out_data_o),
        .done_o       (done_o)
    );

    function automatic tour_t apply_move(input tour_t t, input tsp_pkg::opt_kind_e kind,
                                         input int k, input int l);
        tour_t r;
        r = t;
        case (kind)
            tsp_pkg::OPT_OR0: begin
                for (int p = k; p < l; p++) begin
                    r[p*CW +: CW] = t[(p+1)*CW +: CW];
                end
                r[l*CW +: CW] = t[k*CW +: CW]; // city at k lands at l.
            end
            tsp_pkg::OPT_OR1: begin
                for (int p = k + 1; p <= l; p++) begin
                    r[p*CW +: CW] = t[(p-1)*CW +: CW];
                end
                r[k*CW +: CW] = t[l*CW +: CW];
            end
            tsp_pkg::OPT_TWO: begin
                for (int p = k; p <= l; p++) begin
                    r[p*CW +: CW] = t[(k+l-p)*CW +: CW];
                end
            end
            default: begin
                r = t;
            end
        endcase
        return r;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("%0d mismatches, %0d other errors", mismatches, failures);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // every streamed word is checked against the model while it is stable.
    always @(negedge clk) begin
        if (out_valid_o) begin
            if (!pass_open || words_seen >= `TSP_WORDS) begin
                failures++;
                $display("%s: output word appeared with no pass in flight", test_name);
            end else begin
                if (out_addr_o !== tsp_pkg::word_addr_t'(words_seen)) begin
                    mismatches++;
                    $display("Mismatch %s address: expected %0d, actual %0d",
                             test_name, words_seen, out_addr_o);
                end
                if (out_data_o !== exp_tour[words_seen*WW +: WW]) begin
                    mismatches++;
                    $display("Mismatch %s word %0d: expected %h, actual %h",
                             test_name, words_seen, exp_tour[words_seen*WW +: WW], out_data_o);
                end
                if (done_o !== (words_seen == `TSP_WORDS - 1)) begin
                    mismatches++;
                    $display("Mismatch %s done on word %0d: expected %0d, actual %0d",
                             test_name, words_seen, words_seen == `TSP_WORDS - 1, done_o);
                end
                if (cycle != cmd_cycle + 5 + words_seen) begin
                    mismatches++;
                    $display("Mismatch %s word %0d cycle: expected %0d, actual %0d",
                             test_name, words_seen, cmd_cycle + 5 + words_seen, cycle);
                end
                words_seen++;
            end
        end else if (done_o) begin
            failures++;
            $display("%s: done_o pulsed without an output word", test_name);
        end
    end

    task automatic send_cmd(input tsp_pkg::opt_kind_e kind, input int k, input int l);
        cmd_valid_i = 1'b1;
        cmd_kind_i  = kind;
        cmd_k_i     = tsp_pkg::pos_t'(k);
        cmd_l_i     = tsp_pkg::pos_t'(l);
        @(posedge clk);
        #2;
        cmd_valid_i = 1'b0;
    endtask

    task automatic start_move(input tsp_pkg::opt_kind_e kind, input int k, input int l);
        tour       = apply_move(tour, kind, k, l);
        exp_tour   = tour;
        words_seen = 0;
        pass_open  = 1'b1;
        cmd_cycle  = cycle;
        send_cmd(kind, k, l);
        if (cmd_reject_o !== 1'b0 || busy_o !== 1'b1) begin
            failures++;
            $display("%s: legal command kind %0d k %0d l %0d was not accepted",
                     test_name, kind, k, l);
        end
    endtask

    task automatic finish_move();
        int n;
        n = 0;
        while (busy_o && n < 40) begin
            @(posedge clk);
            #2;
            n++;
        end
        if (busy_o !== 1'b0) begin
            failures++;
            $display("%s: busy_o stayed high after the pass", test_name);
        end else if (cycle != cmd_cycle + 13) begin
            mismatches++;
            $display("Mismatch %s busy release cycle: expected %0d, actual %0d",
                     test_name, cmd_cycle + 13, cycle);
        end
        if (words_seen != `TSP_WORDS) begin
            mismatches++;
            $display("Mismatch %s word count: expected %0d, actual %0d",
                     test_name, `TSP_WORDS, words_seen);
        end
        pass_open = 1'b0;
    endtask

    task automatic run_move(input tsp_pkg::opt_kind_e kind, input int k, input int l);
        start_move(kind, k, l);
        finish_move();
    endtask

    task automatic expect_reject(input tsp_pkg::opt_kind_e kind, input int k, input int l);
        logic was_busy;
        was_busy = busy_o;
        send_cmd(kind, k, l);
        if (cmd_reject_o !== 1'b1) begin
            failures++;
            $display("%s: command kind %0d k %0d l %0d was not rejected", test_name, kind, k, l);
        end
        if (!was_busy && busy_o) begin
            failures++;
            $display("%s: a rejected command started a pass", test_name);
        end
    endtask

    task automatic make_permutation();
        int             j;
        tsp_pkg::city_t c;
        for (int p = 0; p < N_POS; p++) begin
            tour[p*CW +: CW] = CW'(p);
        end
        for (int p = N_POS - 1; p > 0; p--) begin
            j = {$random(seed)} % (p + 1);
            c = tour[p*CW +: CW];
            tour[p*CW +: CW] = tour[j*CW +: CW];
            tour[j*CW +: CW] = c;
        end
    endtask

    task automatic load_tour();
        for (int w = 0; w < `TSP_WORDS; w++) begin
            load_valid_i = 1'b1;
            load_addr_i  = tsp_pkg::word_addr_t'(w);
            load_data_i  = tour[w*WW +: WW];
            @(posedge clk);
            #2;
        end
        load_valid_i = 1'b0;
    endtask

    initial begin
        tsp_pkg::opt_kind_e kind;
        int                 k;
        int                 l;
        int                 t;
        seed         = 32'h5ace9c66;
        test_name    = "reset";
        reset        = 1'b1;
        cmd_valid_i  = 1'b0;
        cmd_kind_i   = tsp_pkg::OPT_NONE;
        cmd_k_i      = '0;
        cmd_l_i      = '0;
        load_valid_i = 1'b0;
        load_addr_i  = '0;
        load_data_i  = '0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        if (busy_o !== 1'b0 || out_valid_o !== 1'b0 ||
            done_o !== 1'b0 || cmd_reject_o !== 1'b0) begin
            failures++;
            $display("outputs were not idle after reset");
        end

        test_name = "pass_through";
        make_permutation();
        load_tour();
        run_move(tsp_pkg::OPT_NONE, 0, 0);

        test_name = "or_forward";
        run_move(tsp_pkg::OPT_OR0, 1, 6);
        run_move(tsp_pkg::OPT_OR0, 5, 30);
        run_move(tsp_pkg::OPT_OR0, 10, 60);
        run_move(tsp_pkg::OPT_OR0, 0, 63);
        run_move(tsp_pkg::OPT_NONE, 0, 0); // the swapped bank must hold the new tour.

        test_name = "or_backward";
        run_move(tsp_pkg::OPT_OR1, 0, 63);
        run_move(tsp_pkg::OPT_OR1, 3, 4);
        run_move(tsp_pkg::OPT_OR1, 12, 41);
        run_move(tsp_pkg::OPT_OR1, 0, 9);
        run_move(tsp_pkg::OPT_NONE, 0, 0);

        test_name = "two_opt";
        run_move(tsp_pkg::OPT_TWO, 2, 5);
        run_move(tsp_pkg::OPT_TWO, 6, 9);
        run_move(tsp_pkg::OPT_TWO, 0, 63);
        run_move(tsp_pkg::OPT_TWO, 17, 46);
        run_move(tsp_pkg::OPT_NONE, 0, 0);

        test_name = "reject";
        expect_reject(tsp_pkg::OPT_OR0, 20, 20);
        expect_reject(tsp_pkg::OPT_TWO, 40, 3);
        expect_reject(tsp_pkg::OPT_OR1, 63, 0);
        start_move(tsp_pkg::OPT_OR0, 4, 50);
        expect_reject(tsp_pkg::OPT_TWO, 1, 2);
        expect_reject(tsp_pkg::OPT_NONE, 0, 0);
        finish_move();
        run_move(tsp_pkg::OPT_NONE, 0, 0);

        test_name = "random";
        for (int i = 0; i < 40; i++) begin
            kind = tsp_pkg::opt_kind_e'($random(seed) & 3);
            k    = $random(seed) & 63;
            l    = $random(seed) & 63;
            if (kind != tsp_pkg::OPT_NONE) begin
                if (k == l) begin
                    if (l < N_POS - 1) begin
                        l = k + 1;
                    end else begin
                        k = N_POS - 2;
                    end
                end
                if (k > l) begin
                    t = k;
                    k = l;
                    l = t;
                end
            end
            run_move(kind, k, l);
        end

        $display("%0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- design/tsp_route_top.sv
module tsp_route_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cmd_valid_i,
    input  tsp_pkg::opt_kind_e   cmd_kind_i,
    input  tsp_pkg::pos_t        cmd_k_i,
    input  tsp_pkg::pos_t        cmd_l_i,
    output logic                 cmd_reject_o,
    output logic                 busy_o,
    input  logic                 load_valid_i,
    input  tsp_pkg::word_addr_t  load_addr_i,
    input  tsp_pkg::route_word_t load_data_i,
    output logic                 out_valid_o,
    output tsp_pkg::word_addr_t  out_addr_o,
    output tsp_pkg::route_word_t out_data_o,
    output logic                 done_o
);

    opt_if opt ();

    tsp_pkg::word_addr_t  rd_a_addr;
    tsp_pkg::word_addr_t  rd_b_addr;
    tsp_pkg::route_word_t rd_a_data;
    tsp_pkg::route_word_t rd_b_data;
    logic                 word_valid;
    tsp_pkg::word_addr_t  word_idx;
    logic                 capture;
    logic                 new_valid;
    tsp_pkg::word_addr_t  new_idx;
    tsp_pkg::route_word_t new_data;
    logic                 wr_valid;
    tsp_pkg::word_addr_t  wr_addr;
    tsp_pkg::route_word_t wr_data;

    opt_decode u_decode (
        .clk          (clk),
        .reset        (reset),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_kind_i   (cmd_kind_i),
        .cmd_k_i      (cmd_k_i),
        .cmd_l_i      (cmd_l_i),
        .cmd_reject_o (cmd_reject_o),
        .busy_o       (busy_o),
        .opt          (opt.decode)
    );

    route_sequencer u_sequencer (
        .clk          (clk),
        .reset        (reset),
        .opt          (opt.execute),
        .rd_a_addr_o  (rd_a_addr),
        .rd_b_addr_o  (rd_b_addr),
        .word_valid_o (word_valid),
        .word_idx_o   (word_idx),
        .capture_o    (capture)
    );

    route_store u_store (
        .clk          (clk),
        .reset        (reset),
        .load_valid_i (load_valid_i),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i),
        .rd_a_addr_i  (rd_a_addr),
        .rd_b_addr_i  (rd_b_addr),
        .rd_a_data_o  (rd_a_data),
        .rd_b_data_o  (rd_b_data),
        .wr_valid_i   (wr_valid),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (wr_data),
        .swap_i       (done_o)
    );

    route_rewrite u_rewrite (
        .clk          (clk),
        .reset        (reset),
        .opt          (opt.execute),
        .capture_i    (capture),
        .word_valid_i (word_valid),
        .word_idx_i   (word_idx),
        .rd_a_data_i  (rd_a_data),
        .rd_b_data_i  (rd_b_data),
        .new_valid_o  (new_valid),
        .new_idx_o    (new_idx),
        .new_data_o   (new_data)
    );

    route_result u_result (
        .clk          (clk),
        .reset        (reset),
        .new_valid_i  (new_valid),
        .new_idx_i    (new_idx),
        .new_data_i   (new_data),
        .out_valid_o  (out_valid_o),
        .out_addr_o   (out_addr_o),
        .out_data_o   (out_data_o),
        .wr_valid_o   (wr_valid),
        .wr_addr_o    (wr_addr),
        .wr_data_o    (wr_data),
        .swap_o       (done_o),
        .opt          (opt.result)
    );

endmodule

//--- design/route_result.sv
`include "tsp_settings.svh"

module route_result (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 new_valid_i,
    input  tsp_pkg::word_addr_t  new_idx_i,
    input  tsp_pkg::route_word_t new_data_i,
    output logic                 out_valid_o,
    output tsp_pkg::word_addr_t  out_addr_o,
    output tsp_pkg::route_word_t out_data_o,
    output logic                 wr_valid_o,
    output tsp_pkg::word_addr_t  wr_addr_o,
    output tsp_pkg::route_word_t wr_data_o,
    output logic                 swap_o,
    opt_if.result                opt
);

    logic done_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_o <= 1'b0;
            done_q      <= 1'b0;
        end else begin
            out_valid_o <= new_valid_i;
            done_q      <= new_valid_i && (new_idx_i == `TSP_WORDS - 1);
        end
    end

    always_ff @(posedge clk) begin
        out_addr_o <= new_idx_i;
        out_data_o <= new_data_i;
    end

    // every streamed word also lands in the shadow bank.
    assign wr_valid_o = out_valid_o;
    assign wr_addr_o  = out_addr_o;
    assign wr_data_o  = out_data_o;

    assign swap_o        = done_q; // banks swap on the edge that writes the last word.
    assign opt.pass_done = done_q;

endmodule

//--- design/route_rewrite.sv
`include "tsp_settings.svh"

module route_rewrite (
    input  logic                 clk,
    input  logic                 reset,
    opt_if.execute               opt,
    input  logic                 capture_i,
    input  logic                 word_valid_i,
    input  tsp_pkg::word_addr_t  word_idx_i,
    input  tsp_pkg::route_word_t rd_a_data_i,
    input  tsp_pkg::route_word_t rd_b_data_i,
    output logic                 new_valid_o,
    output tsp_pkg::word_addr_t  new_idx_o,
    output tsp_pkg::route_word_t new_data_o
);

    localparam int PW = $bits(tsp_pkg::pos_t) + 1;
    localparam int CW = `TSP_CITY_W;

    logic                 capture_d;
    logic                 valid_d;
    tsp_pkg::word_addr_t  idx_d;      // word index aligned with the read data.
    tsp_pkg::route_word_t cap_k_q;    // word holding position k.
    tsp_pkg::route_word_t cap_l_q;    // word holding position l.
    tsp_pkg::city_t       carry;
    tsp_pkg::route_word_t next_word;
    logic [PW-1:0]        k_x;
    logic [PW-1:0]        l_x;
    logic [PW-1:0]        base;
    logic [PW-1:0]        lo;
    tsp_pkg::word_addr_t  mirror_word;
    tsp_pkg::word_addr_t  k_word;
    tsp_pkg::word_addr_t  l_word;

    assign k_x    = PW'(opt.k);
    assign l_x    = PW'(opt.l);
    assign base   = PW'(idx_d * `TSP_LANES);
    assign lo     = (base > k_x) ? base : k_x;
    assign k_word = tsp_pkg::word_addr_t'(opt.k / `TSP_LANES);
    assign l_word = tsp_pkg::word_addr_t'(opt.l / `TSP_LANES);

    // port a carries the higher of the two mirrored words during 2-opt.
    assign mirror_word = tsp_pkg::word_addr_t'((k_x + l_x - lo) / `TSP_LANES);

    // or-opt forward moves the city at k, backward the city at l.
    assign carry = (opt.kind == tsp_pkg::OPT_OR1) ?
                   cap_l_q[(opt.l % `TSP_LANES) * CW +: CW] :
                   cap_k_q[(opt.k % `TSP_LANES) * CW +: CW];

    always_comb begin
        logic [PW-1:0]  p;
        logic [PW-1:0]  s;
        logic           use_b;
        tsp_pkg::city_t city;
        for (int i = 0; i < `TSP_LANES; i++) begin
            p     = base + PW'(i);
            s     = p;
            use_b = 1'b0;
            case (opt.kind)
                tsp_pkg::OPT_OR0: begin
                    if (p >= k_x && p < l_x) begin
                        s = p + 1'b1;
                    end
                    use_b = (s / `TSP_LANES) != idx_d; // only the next word sits on b.
                end
                tsp_pkg::OPT_OR1: begin
                    if (p > k_x && p <= l_x) begin
                        s = p - 1'b1;
                    end
                    use_b = (s / `TSP_LANES) == idx_d; // the current word sits on b.
                end
                tsp_pkg::OPT_TWO: begin
                    if (p >= k_x && p <= l_x) begin
                        s     = k_x + l_x - p;
                        use_b = (s / `TSP_LANES) != mirror_word;
                    end
                end
                default: begin
                    use_b = 1'b0;
                end
            endcase
            city = use_b ? rd_b_data_i[(s % `TSP_LANES) * CW +: CW] :
                           rd_a_data_i[(s % `TSP_LANES) * CW +: CW];
            // untouched lanes next to a reversed run were taken at capture.
            if (opt.kind == tsp_pkg::OPT_TWO && (p < k_x || p > l_x)) begin
                if (idx_d == k_word) begin
                    city = cap_k_q[i * CW +: CW];
                end else if (idx_d == l_word) begin
                    city = cap_l_q[i * CW +: CW];
                end
            end
            if ((opt.kind == tsp_pkg::OPT_OR0 && p == l_x) ||
                (opt.kind == tsp_pkg::OPT_OR1 && p == k_x)) begin
                city = carry;
            end
            next_word[i * CW +: CW] = city;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            capture_d   <= 1'b0;
            valid_d     <= 1'b0;
            new_valid_o <= 1'b0;
        end else begin
            capture_d   <= capture_i;
            valid_d     <= word_valid_i;
            new_valid_o <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        idx_d      <= word_idx_i;
        new_idx_o  <= idx_d;
        new_data_o <= next_word;
        if (capture_d) begin
            cap_k_q <= rd_a_data_i;
            cap_l_q <= rd_b_data_i;
        end
    end

endmodule

//--- design/route_sequencer.sv
`include "tsp_settings.svh"

module route_sequencer (
    input  logic                clk,
    input  logic                reset,
    opt_if.execute              opt,
    output tsp_pkg::word_addr_t rd_a_addr_o,
    output tsp_pkg::word_addr_t rd_b_addr_o,
    output logic                word_valid_o,
    output tsp_pkg::word_addr_t word_idx_o,
    output logic                capture_o
);

    localparam int PW = $bits(tsp_pkg::pos_t) + 1; // one spare bit for k+l and p+1.

    tsp_pkg::seq_state_e state_q;
    tsp_pkg::seq_state_e phase;
    tsp_pkg::word_addr_t word_q;
    logic [PW-1:0]       k_x;
    logic [PW-1:0]       l_x;
    logic [PW-1:0]       p_lo;
    logic [PW-1:0]       p_hi;
    logic [PW-1:0]       s_lo;
    logic [PW-1:0]       s_hi;
    logic [PW:0]         gap;

    // source of position p under an or-opt move, p itself otherwise.
    function automatic logic [PW-1:0] shift_src(input tsp_pkg::opt_kind_e kind,
                                                input logic [PW-1:0] k,
                                                input logic [PW-1:0] l,
                                                input logic [PW-1:0] p);
        logic [PW-1:0] s;
        s = p;
        if (kind == tsp_pkg::OPT_OR0 && p >= k && p < l) begin
            s = p + 1'b1;
        end else if (kind == tsp_pkg::OPT_OR1 && p > k && p <= l) begin
            s = p - 1'b1;
        end
        return s;
    endfunction

    assign k_x  = PW'(opt.k);
    assign l_x  = PW'(opt.l);
    assign p_lo = PW'(word_q * `TSP_LANES);
    assign p_hi = p_lo + PW'(`TSP_LANES - 1);

    // the capture read goes out in the same cycle as start.
    assign phase = opt.start ? tsp_pkg::SEQ_CAPTURE : state_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= tsp_pkg::SEQ_IDLE;
            word_q  <= '0;
        end else if (phase == tsp_pkg::SEQ_CAPTURE) begin
            state_q <= tsp_pkg::SEQ_STREAM;
            word_q  <= '0;
        end else if (phase == tsp_pkg::SEQ_STREAM) begin
            word_q <= word_q + 1'b1;
            if (word_q == `TSP_WORDS - 1) begin
                state_q <= tsp_pkg::SEQ_IDLE;
            end
        end
    end

    always_comb begin
        logic [PW-1:0] lo;
        logic [PW-1:0] hi;
        lo = (p_lo > k_x) ? p_lo : k_x;
        hi = (p_hi < l_x) ? p_hi : l_x;
        if (opt.kind == tsp_pkg::OPT_TWO && p_hi >= k_x && p_lo <= l_x) begin
            s_lo = k_x + l_x - lo; // mirrored, so port a holds the higher word.
            s_hi = k_x + l_x - hi;
        end else begin
            s_lo = shift_src(opt.kind, k_x, l_x, p_lo);
            s_hi = shift_src(opt.kind, k_x, l_x, p_hi);
        end
    end

    assign capture_o    = (phase == tsp_pkg::SEQ_CAPTURE);
    assign word_valid_o = (phase == tsp_pkg::SEQ_STREAM);
    assign word_idx_o   = word_q;

    // capture reads both edge words, they hold the carried city and the 2-opt edges.
    assign rd_a_addr_o = capture_o ? tsp_pkg::word_addr_t'(opt.k / `TSP_LANES)
                                   : tsp_pkg::word_addr_t'(s_lo / `TSP_LANES);
    assign rd_b_addr_o = capture_o ? tsp_pkg::word_addr_t'(opt.l / `TSP_LANES)
                                   : tsp_pkg::word_addr_t'(s_hi / `TSP_LANES);

    assign gap = {1'b0, rd_a_addr_o} - {1'b0, rd_b_addr_o};

    a_pair_adjacent: assert property (@(posedge clk) disable iff (reset)
        word_valid_o |-> (gap == '0 || gap == (PW+1)'(1) || gap == '1));

endmodule

//--- design/route_store.sv
`include "tsp_settings.svh"

module route_store (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 load_valid_i,
    input  tsp_pkg::word_addr_t  load_addr_i,
    input  tsp_pkg::route_word_t load_data_i,
    input  tsp_pkg::word_addr_t  rd_a_addr_i,
    input  tsp_pkg::word_addr_t  rd_b_addr_i,
    output tsp_pkg::route_word_t rd_a_data_o,
    output tsp_pkg::route_word_t rd_b_data_o,
    input  logic                 wr_valid_i,
    input  tsp_pkg::word_addr_t  wr_addr_i,
    input  tsp_pkg::route_word_t wr_data_i,
    input  logic                 swap_i
);

    tsp_pkg::route_word_t bank_q [2][`TSP_WORDS];
    logic                 active_q; // bank holding the current tour.

    always_ff @(posedge clk) begin
        if (reset) begin
            active_q <= 1'b0;
        end else if (swap_i) begin
            active_q <= ~active_q;
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid_i) begin
            bank_q[active_q][load_addr_i] <= load_data_i;
        end
        if (wr_valid_i) begin
            bank_q[~active_q][wr_addr_i] <= wr_data_i; // shadow bank collects the new tour.
        end
        rd_a_data_o <= bank_q[active_q][rd_a_addr_i];
        rd_b_data_o <= bank_q[active_q][rd_b_addr_i];
    end

    a_no_load_during_pass: assert property (@(posedge clk) disable iff (reset)
        !(load_valid_i && wr_valid_i));

endmodule

//--- design/opt_decode.sv
module opt_decode (
    input  logic               clk,
    input  logic               reset,
    input  logic               cmd_valid_i,
    input  tsp_pkg::opt_kind_e cmd_kind_i,
    input  tsp_pkg::pos_t      cmd_k_i,
    input  tsp_pkg::pos_t      cmd_l_i,
    output logic               cmd_reject_o,
    output logic               busy_o,
    opt_if.decode              opt
);

    logic legal;
    logic accept;

    assign legal  = (cmd_kind_i == tsp_pkg::OPT_NONE) || (cmd_k_i < cmd_l_i);
    assign accept = cmd_valid_i && legal && !busy_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            opt.start    <= 1'b0;
            busy_o       <= 1'b0;
            cmd_reject_o <= 1'b0;
        end else begin
            opt.start    <= accept;
            cmd_reject_o <= cmd_valid_i && !accept; // bad positions or sent while busy.
            if (accept) begin
                busy_o <= 1'b1;
            end else if (opt.pass_done) begin
                busy_o <= 1'b0;
            end
        end
    end

    // the move stays put until the next accepted command, so it is stable for a whole pass.
    always_ff @(posedge clk) begin
        if (accept) begin
            opt.kind <= cmd_kind_i;
            opt.k    <= cmd_k_i;
            opt.l    <= cmd_l_i;
        end
    end

    // a pass can only end while a move is in flight.
    a_done_while_busy: assert property (@(posedge clk) disable iff (reset)
        opt.pass_done |-> busy_o);

endmodule

//--- design/opt_if.sv
interface opt_if;

    logic               start;     // one cycle strobe per accepted move.
    tsp_pkg::opt_kind_e kind;
    tsp_pkg::pos_t      k;
    tsp_pkg::pos_t      l;
    logic               pass_done; // last rewritten word has been written.

    modport decode (
        output start, kind, k, l,
        input  pass_done
    );

    modport execute (
        input start, kind, k, l
    );

    modport result (
        output pass_done
    );

endinterface

//--- design/tsp_pkg.sv
`include "tsp_settings.svh"

package tsp_pkg;

    typedef logic [`TSP_CITY_W-1:0] city_t;

    // a tour position, word times lanes plus lane.
    typedef logic [$clog2(`TSP_LANES*`TSP_WORDS)-1:0] pos_t;

    typedef logic [$clog2(`TSP_WORDS)-1:0] word_addr_t;

    typedef logic [`TSP_LANES*`TSP_CITY_W-1:0] route_word_t; // lane 0 sits in the low bits.

    typedef enum logic [1:0] {
        OPT_NONE,
        OPT_OR0,
        OPT_OR1,
        OPT_TWO
    } opt_kind_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_CAPTURE,
        SEQ_STREAM
    } seq_state_e;

endpackage

//--- design/tsp_settings.svh
`ifndef TSP_SETTINGS_SVH
`define TSP_SETTINGS_SVH

// one tour is TSP_WORDS words of TSP_LANES cities each.
// the position of a city is its word times TSP_LANES plus its lane.

// cities packed into one memory word.
`define TSP_LANES 8

// words in one tour.
`define TSP_WORDS 8

// bits of one city number.
`define TSP_CITY_W 6

`endif
